/* verilog.f */
+incdir+.
gbCpuPkg.sv
ucodeStore.sv
flowSequencer.sv
regFile.sv
aluFlags.sv
memBusPort.sv
gbCpuTop.sv
tbChecker.sv
tbGbCpu.sv

/* run.sh */
#!/bin/sh
# Build and run the gbCpu testbench with Verilator

logFile=sim.log

verilator --binary --timing --timescale 1ns/1ps -f verilog.f --top-module tbGbCpu -o simGbCpu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simGbCpu > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
  echo "Simulation returned status $simStatus"
  exit 1
fi

if grep -q "TEST RESULT: FAIL" "$logFile"; then
  echo "Failure reported in $logFile"
  exit 1
fi

echo "No failure reported in $logFile"
exit 0

/* tbGbCpu.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module tbGbCpu;

  localparam int txnTarget  = 3000;
  localparam int runLimit   = 100000;  // Cycles for the whole run
  localparam int stallLimit = 100;

  logic                  iClock;
  logic                  arstN;
  logic                  req;
  logic                  ack;
  logic [`GB_DATA_W-1:0] rdata;
  gbCpuPkg::busReqT      busOut;
  logic [7:0]            mem [65536];
  logic                  respHung;
  logic                  runHung;
  int                    errorCount;
  int                    txnCount;

  gbCpuTop dut0
  (
    .iClock (iClock),
    .arstN  (arstN),
    .req    (req),
    .busOut (busOut),
    .ack    (ack),
    .rdata  (rdata)
  );

  tbChecker chk0
  (
    .iClock     (iClock),
    .arstN      (arstN),
    .req        (req),
    .busOut     (busOut),
    .ack        (ack),
    .memImage   (mem),
    .errorCount (errorCount),
    .txnCount   (txnCount)
  );

  initial
  begin
    iClock = 1'b0;
    forever #2 iClock = ~iClock;
  end

  // ------------------------------------------------------------
  // Random program
  // ------------------------------------------------------------
  function automatic logic [2:0] pickReg();
    logic [2:0] r;
    r = 3'($urandom % 7);
    return (r == 3'd6) ? 3'd7 : r;  // Skip the (HL) slot
  endfunction

  function automatic logic [2:0] pickAluKind();
    logic [2:0] k;
    k = 3'($urandom % 6);
    return (k >= 3'd3) ? k + 3'd1 : k;  // ADD ADC SUB AND XOR OR
  endfunction

  task automatic placeInstr(input int addr, output int len);
    int unsigned pick;
    logic [2:0]  r;
    logic [2:0]  s;
    pick = $urandom % 16;
    r    = pickReg();
    s    = pickReg();
    len  = 1;
    case (pick)
      0, 1, 2:
      begin
        mem[16'(addr)]     = {2'b00, r, 3'b110};  // LD r,n
        mem[16'(addr + 1)] = 8'($urandom);
        len                = 2;
      end
      3, 4, 5:      mem[16'(addr)] = {2'b01, r, s};
      6, 7:         mem[16'(addr)] = {2'b01, 3'd6, s};
      8, 9, 10, 11: mem[16'(addr)] = {2'b10, pickAluKind(), s};
      12, 13:       mem[16'(addr)] = {2'b00, r, 2'b10, 1'($urandom)};
      14:
      begin
        mem[16'(addr)]     = 8'h20;
        mem[16'(addr + 1)] = 8'(($urandom % 20) - 4);  // Mostly forward
        len                = 2;
      end
      default:      mem[16'(addr)] = 8'($urandom);
    endcase
  endtask

  task automatic buildMemory();
    int addr;
    int len;
    for (int a = 0; a < 65536; a++)
      mem[16'(a)] = 8'(a) ^ 8'(a >> 8) ^ 8'h3c;
    addr = 0;
    while (addr < 251)
    begin
      placeInstr(addr, len);
      addr = addr + len;
    end
    // LD A,1; OR A; JR NZ back to 0x80
    mem[16'd251] = 8'h3e;
    mem[16'd252] = 8'h01;
    mem[16'd253] = 8'hb7;
    mem[16'd254] = 8'h20;
    mem[16'd255] = 8'h80;
  endtask

  // ------------------------------------------------------------
  // Memory responder
  // ------------------------------------------------------------
  initial
  begin
    int waitCount;
    int delay;
    ack      = 1'b0;
    rdata    = '0;
    respHung = 1'b0;
    void'($urandom(32'h471a));
    buildMemory();
    while (!respHung)
    begin
      waitCount = 0;
      while (req !== 1'b1 && !respHung)
      begin
        @(posedge iClock);
        #1;
        waitCount++;
        if (waitCount > stallLimit)
        begin
          $display("ERROR: no bus request for %0d cycles", stallLimit);
          respHung = 1'b1;
        end
      end
      if (!respHung)
      begin
        delay = $urandom % 4;
        repeat (delay)
        begin
          @(posedge iClock);
          #1;
        end
        if (busOut.we)
          mem[busOut.addr] = busOut.wdata;
        else
          rdata = mem[busOut.addr];
        ack       = 1'b1;
        waitCount = 0;
        while (req === 1'b1 && !respHung)
        begin
          @(posedge iClock);
          #1;
          waitCount++;
          if (waitCount > stallLimit)
          begin
            $display("ERROR: req stayed high %0d cycles after ack", stallLimit);
            respHung = 1'b1;
          end
        end
        delay = $urandom % 4;
        repeat (delay)
        begin
          @(posedge iClock);
          #1;
        end
        ack = 1'b0;
      end
    end
  end

  // Reset and run control
  initial
  begin
    int cycles;
    arstN   = 1'b0;
    runHung = 1'b0;
    repeat (8) @(posedge iClock);
    #1;
    arstN  = 1'b1;
    cycles = 0;
    while (txnCount < txnTarget && !respHung && !runHung)
    begin
      @(posedge iClock);
      #1;
      cycles++;
      if (cycles > runLimit)
      begin
        $display("ERROR: only %0d of %0d transactions after %0d cycles", txnCount, txnTarget,
                 runLimit);
        runHung = 1'b1;
      end
    end
    $display("Transactions %0d, check errors %0d, timeouts %0d", txnCount, errorCount,
             int'(respHung) + int'(runHung));
    if (errorCount == 0 && !respHung && !runHung)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* tbChecker.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module tbChecker
(
  input  logic                  iClock,
  input  logic                  arstN,
  input  logic                  req,
  input  gbCpuPkg::busReqT      busOut,
  input  logic                  ack,
  input  logic [`GB_DATA_W-1:0] memImage [65536],
  output int                    errorCount,
  output int                    txnCount
);

  logic [7:0]       memMirror [65536];
  logic [7:0]       regs [8];   // Z80 order, slot 6 unused
  logic [15:0]      pc;
  logic             fz;
  logic             fn;
  logic             fh;
  logic             fc;
  logic [15:0]      expAddr [$];
  logic             expWe [$];
  logic [7:0]       expData [$];
  string            expName [$];
  gbCpuPkg::busReqT held;
  logic             reqPrev = 1'b0;
  logic             ackPrev = 1'b0;
  int               errs = 0;
  int               txns = 0;

  assign errorCount = errs;
  assign txnCount   = txns;

  task automatic reportMismatch(input string testName, input logic [15:0] expVal,
                                input logic [15:0] actVal);
    $display("CHECK FAILED %s: expected 0x%0h, actual 0x%0h", testName, expVal, actVal);
    errs++;
  endtask

  task automatic reportProtocol(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    errs++;
  endtask

  task automatic pushTxn(input logic [15:0] addr, input logic we, input logic [7:0] data,
                         input string name);
    expAddr.push_back(addr);
    expWe.push_back(we);
    expData.push_back(data);
    expName.push_back(name);
  endtask

  task automatic readAtPc(input string name, output logic [7:0] value);
    value = memMirror[pc];
    pushTxn(pc, 1'b0, 8'h00, name);
    pc = pc + 16'd1;
  endtask

  // ------------------------------------------------------------
  // Instruction-level model
  // ------------------------------------------------------------
  task automatic runAlu(input logic [2:0] kind, input logic [7:0] b);
    logic [7:0] a;
    int         full;
    int         low;
    int         cin;
    a   = regs[7];
    cin = (kind == 3'd1 && fc) ? 1 : 0;   // ADC only
    case (kind)
      3'd0, 3'd1:
      begin
        full    = int'(a) + int'(b) + cin;
        low     = int'(a[3:0]) + int'(b[3:0]) + cin;
        regs[7] = 8'(full);
        fn      = 1'b0;
        fh      = low > 15;
        fc      = full > 255;
      end
      3'd2:
      begin
        fh      = a[3:0] < b[3:0];
        fc      = a < b;
        fn      = 1'b1;
        regs[7] = a - b;
      end
      3'd4:
      begin
        regs[7]      = a & b;
        {fn, fh, fc} = 3'b010;
      end
      3'd5:
      begin
        regs[7]      = a ^ b;
        {fn, fh, fc} = 3'b000;
      end
      default:
      begin
        regs[7]      = a | b;
        {fn, fh, fc} = 3'b000;
      end
    endcase
    fz = regs[7] == 8'h00;
  endtask

  task automatic runIncDec(input logic [2:0] r, input logic isDec);
    logic [7:0] v;
    v = regs[r];
    if (isDec)
    begin
      fh      = v[3:0] == 4'h0;  // Borrow into bit 3
      fn      = 1'b1;
      regs[r] = v - 8'd1;
    end
    else
    begin
      fh      = v[3:0] == 4'hf;
      fn      = 1'b0;
      regs[r] = v + 8'd1;
    end
    fz = regs[r] == 8'h00;
  endtask

  task automatic stepModel();
    logic [7:0]  op;
    logic [7:0]  imm;
    logic [2:0]  dst;
    logic [2:0]  src;
    logic [15:0] hl;
    readAtPc("fetch", op);
    dst = op[5:3];
    src = op[2:0];
    hl  = {regs[4], regs[5]};
    if (op == 8'h20)
    begin
      readAtPc("JR NZ offset", imm);
      if (!fz)
        pc = pc + {{8{imm[7]}}, imm};
    end
    else if (op[7:6] == 2'b00 && dst != 3'd6 && src == 3'd6)
    begin
      readAtPc("LD r,n immediate", imm);
      regs[dst] = imm;
    end
    else if (op[7:6] == 2'b00 && dst != 3'd6 && src[2:1] == 2'b10)
      runIncDec(dst, src[0]);
    else if (op[7:6] == 2'b01 && src != 3'd6)
    begin
      if (dst == 3'd6)
      begin
        pushTxn(hl, 1'b1, regs[src], "LD (HL),r");
        memMirror[hl] = regs[src];
      end
      else
        regs[dst] = regs[src];
    end
    else if (op[7:6] == 2'b10 && src != 3'd6 && dst != 3'd3 && dst != 3'd7)
      runAlu(dst, regs[src]);
  endtask

  task automatic compareTxn();
    logic [15:0] eAddr;
    logic        eWe;
    logic [7:0]  eData;
    string       name;
    eAddr = expAddr.pop_front();
    eWe   = expWe.pop_front();
    eData = expData.pop_front();
    name  = expName.pop_front();
    if (busOut.addr !== eAddr)
      reportMismatch({name, " address"}, eAddr, busOut.addr);
    if (busOut.we !== eWe)
      reportMismatch({name, " we"}, 16'(eWe), 16'(busOut.we));
    else if (eWe && busOut.wdata !== eData)
      reportMismatch({name, " wdata"}, 16'(eData), 16'(busOut.wdata));
  endtask

  // ------------------------------------------------------------
  // Bus monitor, sampled mid-cycle
  // ------------------------------------------------------------
  always @(negedge iClock)
  begin
    if (!arstN)
    begin
      if (req !== 1'b0 || busOut.we !== 1'b0)
        reportProtocol("req or we not low during reset");
      for (int i = 0; i < 65536; i++)
        memMirror[16'(i)] = memImage[16'(i)];
      for (int i = 0; i < 8; i++)
        regs[3'(i)] = 8'h00;
      pc               = `GB_RESET_PC;
      {fz, fn, fh, fc} = 4'(`GB_FLAGS_RESET >> 4);
      expAddr.delete();
      expWe.delete();
      expData.delete();
      expName.delete();
    end
    else
    begin
      if (txns == 0 && !req && busOut.we)
        reportProtocol("we went high before the first request");
      if (req && !reqPrev)
      begin
        if (ackPrev)
          reportProtocol("req rose before ack fell");
        if (expAddr.size() == 0)
          stepModel();
        compareTxn();
        held = busOut;
        txns++;
      end
      else if (req && busOut !== held)
        reportProtocol("busOut changed while req was high");
    end
    reqPrev = req;
    ackPrev = ack;
  end

endmodule

/* gbCpuTop.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module gbCpuTop
(
  input  logic                  iClock,
  input  logic                  arstN,
  output logic                  req,
  output gbCpuPkg::busReqT      busOut,
  input  logic                  ack,
  input  logic [`GB_DATA_W-1:0] rdata
);

  gbCpuPkg::uopT         uop;
  gbCpuPkg::flagsT       flags;
  gbCpuPkg::regWriteT    write;
  gbCpuPkg::regIdxT      srcIdx;
  gbCpuPkg::busReqT      busReq;
  logic                  flowEnable;
  logic                  busStart;
  logic                  busDone;
  logic                  pcInc;
  logic                  pcLoad;
  logic [`GB_DATA_W-1:0] opcode;
  logic [`GB_DATA_W-1:0] readByte;
  logic [`GB_DATA_W-1:0] operand;
  logic [`GB_DATA_W-1:0] accum;
  logic [`GB_ADDR_W-1:0] hl;
  logic [`GB_ADDR_W-1:0] pc;
  logic [`GB_ADDR_W-1:0] pcNext;

  flowSequencer seq0
  (
    .iClock(iClock), .arstN(arstN), .busDone(busDone), .rdata(readByte), .flags(flags),
    .uop(uop), .flowEnable(flowEnable), .opcode(opcode), .busStart(busStart), .pcInc(pcInc)
  );

  regFile reg0
  (
    .iClock(iClock), .arstN(arstN), .write(write), .srcIdx(srcIdx), .pcInc(pcInc),
    .pcLoad(pcLoad), .pcNext(pcNext), .operand(operand), .accum(accum), .hl(hl), .pc(pc)
  );

  aluFlags alu0
  (
    .iClock(iClock), .arstN(arstN), .uop(uop), .flowEnable(flowEnable), .opcode(opcode),
    .operand(operand), .accum(accum), .imm(readByte), .pc(pc), .hl(hl), .write(write),
    .flags(flags), .pcLoad(pcLoad), .pcNext(pcNext), .srcIdx(srcIdx), .busReq(busReq)
  );

  memBusPort bus0
  (
    .iClock(iClock), .arstN(arstN), .start(busStart), .reqIn(busReq), .req(req),
    .busOut(busOut), .ack(ack), .rdata(rdata), .readByte(readByte), .busDone(busDone)
  );

endmodule

/* memBusPort.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module memBusPort
(
  input  logic                  iClock,
  input  logic                  arstN,
  input  logic                  start,
  input  gbCpuPkg::busReqT      reqIn,
  output logic                  req,
  output gbCpuPkg::busReqT      busOut,
  input  logic                  ack,
  input  logic [`GB_DATA_W-1:0] rdata,
  output logic [`GB_DATA_W-1:0] readByte,
  output logic                  busDone
);

  typedef enum logic [1:0] {idle, waitAck, waitAckLow, done} busStateE;

  busStateE state;

  // ------------------------------------------------------------
  // Four-phase handshake
  // ------------------------------------------------------------
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      state  <= idle;
      busOut <= '0;
    end
    else
      case (state)
        idle:
        begin
          if (start)
          begin
            busOut <= reqIn;  // Frozen until the next start
            state  <= waitAck;
          end
        end
        waitAck:    if (ack) state <= waitAckLow;
        waitAckLow: if (!ack) state <= done;
        default:    state <= idle;
      endcase
  end

  always_ff @(posedge iClock)
  begin
    if (state == waitAck && ack)
      readByte <= rdata;
  end

  assign req     = state == waitAck;
  assign busDone = state == done;

endmodule

/* aluFlags.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module aluFlags
(
  input  logic                  iClock,
  input  logic                  arstN,
  input  gbCpuPkg::uopT         uop,
  input  logic                  flowEnable,
  input  logic [`GB_DATA_W-1:0] opcode,
  input  logic [`GB_DATA_W-1:0] operand,
  input  logic [`GB_DATA_W-1:0] accum,
  input  logic [`GB_DATA_W-1:0] imm,
  input  logic [`GB_ADDR_W-1:0] pc,
  input  logic [`GB_ADDR_W-1:0] hl,
  output gbCpuPkg::regWriteT    write,
  output gbCpuPkg::flagsT       flags,
  output logic                  pcLoad,
  output logic [`GB_ADDR_W-1:0] pcNext,
  output gbCpuPkg::regIdxT      srcIdx,
  output gbCpuPkg::busReqT      busReq
);

  gbCpuPkg::aluOpE  op;
  gbCpuPkg::flagsT  flagsNext;
  logic [8:0]       sum;
  logic [4:0]       nib;
  logic             flagsWe;

  assign srcIdx = gbCpuPkg::regIdxT'(uop.srcHigh ? opcode[5:3] : opcode[2:0]);

  always_comb
  begin
    if (uop.cmd == gbCpuPkg::cmdIncDec)
      op = opcode[0] ? gbCpuPkg::aluDec : gbCpuPkg::aluInc;
    else
      case (opcode[5:3])
        3'd0:    op = gbCpuPkg::aluAdd;
        3'd1:    op = gbCpuPkg::aluAdc;
        3'd2:    op = gbCpuPkg::aluSub;
        3'd4:    op = gbCpuPkg::aluAnd;
        3'd5:    op = gbCpuPkg::aluXor;
        default: op = gbCpuPkg::aluOr;
      endcase
  end

  // ------------------------------------------------------------
  // Result and flag rules
  // ------------------------------------------------------------
  always_comb
  begin
    flagsNext = flags;
    nib       = '0;
    case (op)
      gbCpuPkg::aluAdd, gbCpuPkg::aluAdc:
      begin
        sum = {1'b0, accum} + {1'b0, operand} +
              ((op == gbCpuPkg::aluAdc) ? {8'd0, flags.c} : 9'd0);
        nib = {1'b0, accum[3:0]} + {1'b0, operand[3:0]} +
              ((op == gbCpuPkg::aluAdc) ? {4'd0, flags.c} : 5'd0);
        {flagsNext.n, flagsNext.h, flagsNext.c} = {1'b0, nib[4], sum[8]};
      end
      gbCpuPkg::aluSub:
      begin
        sum = {1'b0, accum} - {1'b0, operand};
        nib = {1'b0, accum[3:0]} - {1'b0, operand[3:0]};  // Bit 4 is the borrow
        {flagsNext.n, flagsNext.h, flagsNext.c} = {1'b1, nib[4], sum[8]};
      end
      gbCpuPkg::aluAnd:
      begin
        sum = {1'b0, accum & operand};
        {flagsNext.n, flagsNext.h, flagsNext.c} = 3'b010;
      end
      gbCpuPkg::aluXor, gbCpuPkg::aluOr:
      begin
        sum = {1'b0, (op == gbCpuPkg::aluXor) ? (accum ^ operand) : (accum | operand)};
        {flagsNext.n, flagsNext.h, flagsNext.c} = 3'b000;
      end
      gbCpuPkg::aluInc:
      begin
        sum         = {1'b0, operand} + 9'd1;
        flagsNext.n = 1'b0;
        flagsNext.h = sum[3:0] == 4'h0;  // C untouched
      end
      default:
      begin
        sum         = {1'b0, operand} - 9'd1;
        flagsNext.n = 1'b1;
        flagsNext.h = sum[3:0] == 4'hf;
      end
    endcase
    flagsNext.z    = sum[7:0] == '0;
    flagsNext.zero = '0;
  end

  assign flagsWe = flowEnable &&
                   (uop.cmd == gbCpuPkg::cmdAluOp || uop.cmd == gbCpuPkg::cmdIncDec);

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      flags <= gbCpuPkg::flagsT'(`GB_FLAGS_RESET);
    else if (flagsWe)
      flags <= flagsNext;
  end

  // Register write back
  always_comb
  begin
    write.en  = flowEnable && (uop.cmd == gbCpuPkg::cmdLoadImm || uop.cmd == gbCpuPkg::cmdMove ||
                               flagsWe);
    write.idx = (uop.cmd == gbCpuPkg::cmdAluOp) ? gbCpuPkg::regA
                                                : gbCpuPkg::regIdxT'(opcode[5:3]);
    case (uop.cmd)
      gbCpuPkg::cmdLoadImm: write.data = imm;
      gbCpuPkg::cmdMove:    write.data = operand;
      default:              write.data = sum[7:0];
    endcase
  end

  assign pcLoad = flowEnable && uop.cmd == gbCpuPkg::cmdJumpRel;
  assign pcNext = pc + {{(`GB_ADDR_W-`GB_DATA_W){imm[`GB_DATA_W-1]}}, imm};  // PC past offset

  assign busReq.addr  = (uop.cmd == gbCpuPkg::cmdStoreHl) ? hl : pc;
  assign busReq.wdata = operand;
  assign busReq.we    = uop.cmd == gbCpuPkg::cmdStoreHl;

endmodule

/* regFile.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module regFile
(
  input  logic                  iClock,
  input  logic                  arstN,
  input  gbCpuPkg::regWriteT    write,
  input  gbCpuPkg::regIdxT      srcIdx,
  input  logic                  pcInc,
  input  logic                  pcLoad,
  input  logic [`GB_ADDR_W-1:0] pcNext,
  output logic [`GB_DATA_W-1:0] operand,
  output logic [`GB_DATA_W-1:0] accum,
  output logic [2*`GB_DATA_W-1:0] hl,
  output logic [`GB_ADDR_W-1:0] pc
);

  // Indexed by Z80 field, slot 6 stays zero
  logic [`GB_DATA_W-1:0] gpr [8];

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      for (int i = 0; i < 8; i++)
        gpr[i] <= '0;
    end
    else if (write.en && write.idx != gbCpuPkg::regHlMem)
      gpr[write.idx] <= write.data;
  end

  // JR target wins over the fetch increment
  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
      pc <= `GB_RESET_PC;
    else if (pcLoad)
      pc <= pcNext;
    else if (pcInc)
      pc <= pc + `GB_ADDR_W'(1);
  end

  assign operand = gpr[srcIdx];
  assign accum   = gpr[gbCpuPkg::regA];
  assign hl      = {gpr[gbCpuPkg::regH], gpr[gbCpuPkg::regL]};

endmodule

/* flowSequencer.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module flowSequencer
(
  input  logic                  iClock,
  input  logic                  arstN,
  input  logic                  busDone,
  input  logic [`GB_DATA_W-1:0] rdata,
  input  gbCpuPkg::flagsT       flags,
  output gbCpuPkg::uopT         uop,
  output logic                  flowEnable,
  output logic [`GB_DATA_W-1:0] opcode,
  output logic                  busStart,
  output logic                  pcInc
);

  typedef enum logic [1:0] {afterReset, startFlow, runFlow, endFlow} seqStateE;

  seqStateE               state;
  seqStateE               stateNext;
  logic [`GB_UPC_W-1:0]   upc;
  logic [`GB_UPC_W-1:0]   flowIdx;
  logic                   isBus;
  logic                   stepDone;
  logic                   eofHit;

  ucodeStore store0
  (
    .upc     (upc),
    .opcode  (rdata),
    .uop     (uop),
    .flowIdx (flowIdx)
  );

  assign isBus = uop.cmd == gbCpuPkg::cmdFetch || uop.cmd == gbCpuPkg::cmdReadImm ||
                 uop.cmd == gbCpuPkg::cmdStoreHl;
  assign stepDone   = !isBus || busDone;  // Bus ops hold until the handshake ends
  assign flowEnable = state == runFlow;
  assign busStart   = flowEnable && isBus;
  assign pcInc      = flowEnable && busDone &&
                      (uop.cmd == gbCpuPkg::cmdFetch || uop.cmd == gbCpuPkg::cmdReadImm);

  always_comb
  begin
    case (uop.eof)
      gbCpuPkg::eofEnd:     eofHit = 1'b1;
      gbCpuPkg::eofEndIfZ:  eofHit = flags.z;
      gbCpuPkg::eofEndIfNz: eofHit = !flags.z;
      default:              eofHit = 1'b0;
    endcase
  end

  // ------------------------------------------------------------
  // State machine
  // ------------------------------------------------------------
  always_comb
  begin
    case (state)
      afterReset: stateNext = startFlow;
      startFlow:  stateNext = runFlow;
      runFlow:    stateNext = (stepDone && eofHit) ? endFlow : runFlow;
      default:    stateNext = startFlow;
    endcase
  end

  always_ff @(posedge iClock or negedge arstN)
  begin
    if (!arstN)
    begin
      state  <= afterReset;
      upc    <= `GB_FLOW_FETCH;
      opcode <= '0;
    end
    else
    begin
      state <= stateNext;
      if (state == startFlow)
        upc <= `GB_FLOW_FETCH;
      else if (flowEnable && stepDone)
        upc <= (uop.cmd == gbCpuPkg::cmdDispatch) ? flowIdx : upc + `GB_UPC_W'(1);
      if (flowEnable && uop.cmd == gbCpuPkg::cmdDispatch)
        opcode <= rdata;  // Fetched byte still held by the bus port
    end
  end

endmodule

/* ucodeStore.sv */
`timescale 1ns/1ps
`include "gbCpu_params.svh"

module ucodeStore
(
  input  logic [`GB_UPC_W-1:0]  upc,
  input  logic [`GB_DATA_W-1:0] opcode,
  output gbCpuPkg::uopT         uop,
  output logic [`GB_UPC_W-1:0]  flowIdx
);

  // Flow entry points
  localparam logic [`GB_UPC_W-1:0] flowDispatch = `GB_FLOW_FETCH + 6'd1;
  localparam logic [`GB_UPC_W-1:0] flowLdRn     = 6'd4;
  localparam logic [`GB_UPC_W-1:0] flowLdRnWr   = 6'd5;
  localparam logic [`GB_UPC_W-1:0] flowLdRr     = 6'd6;
  localparam logic [`GB_UPC_W-1:0] flowStHl     = 6'd7;
  localparam logic [`GB_UPC_W-1:0] flowAlu      = 6'd8;
  localparam logic [`GB_UPC_W-1:0] flowIncDec   = 6'd9;
  localparam logic [`GB_UPC_W-1:0] flowJrNz     = 6'd10;
  localparam logic [`GB_UPC_W-1:0] flowJrTest   = 6'd11;
  localparam logic [`GB_UPC_W-1:0] flowJrJump   = 6'd12;
  localparam logic [`GB_UPC_W-1:0] flowNop      = 6'd13;

  function automatic gbCpuPkg::uopT mkUop(input gbCpuPkg::uopCmdE cmd,
                                          input gbCpuPkg::eofSelE eof,
                                          input logic srcHigh);
    gbCpuPkg::uopT word;
    word.cmd     = cmd;
    word.eof     = eof;
    word.srcHigh = srcHigh;
    return word;
  endfunction

  // ------------------------------------------------------------
  // Micro-op ROM
  // ------------------------------------------------------------
  always_comb
  begin
    case (upc)
      `GB_FLOW_FETCH: uop = mkUop(gbCpuPkg::cmdFetch, gbCpuPkg::eofContinue, 1'b0);
      flowDispatch:   uop = mkUop(gbCpuPkg::cmdDispatch, gbCpuPkg::eofContinue, 1'b0);
      flowLdRn:       uop = mkUop(gbCpuPkg::cmdReadImm, gbCpuPkg::eofContinue, 1'b0);
      flowLdRnWr:     uop = mkUop(gbCpuPkg::cmdLoadImm, gbCpuPkg::eofEnd, 1'b0);
      flowLdRr:       uop = mkUop(gbCpuPkg::cmdMove, gbCpuPkg::eofEnd, 1'b0);
      flowStHl:       uop = mkUop(gbCpuPkg::cmdStoreHl, gbCpuPkg::eofEnd, 1'b0);
      flowAlu:        uop = mkUop(gbCpuPkg::cmdAluOp, gbCpuPkg::eofEnd, 1'b0);
      flowIncDec:     uop = mkUop(gbCpuPkg::cmdIncDec, gbCpuPkg::eofEnd, 1'b1);
      flowJrNz:       uop = mkUop(gbCpuPkg::cmdReadImm, gbCpuPkg::eofContinue, 1'b0);
      flowJrTest:     uop = mkUop(gbCpuPkg::cmdNop, gbCpuPkg::eofEndIfZ, 1'b0); // Not taken
      flowJrJump:     uop = mkUop(gbCpuPkg::cmdJumpRel, gbCpuPkg::eofEnd, 1'b0);
      default:        uop = mkUop(gbCpuPkg::cmdNop, gbCpuPkg::eofEnd, 1'b0);
    endcase
  end

  // Opcode class lookup
  always_comb
  begin
    flowIdx = flowNop;
    if (opcode == `GB_OP_JR_NZ)
      flowIdx = flowJrNz;
    else if (opcode[7:6] == 2'b00 && opcode[5:3] != `GB_HL_MEM_FIELD)
    begin
      if (opcode[2:1] == 2'b10)
        flowIdx = flowIncDec;  // INC r / DEC r
      else if (opcode[2:0] == 3'd6)
        flowIdx = flowLdRn;
    end
    else if (opcode[7:6] == 2'b01 && opcode[2:0] != `GB_HL_MEM_FIELD)
      flowIdx = (opcode[5:3] == `GB_HL_MEM_FIELD) ? flowStHl : flowLdRr;
    else if (opcode[7:6] == 2'b10 && opcode[2:0] != `GB_HL_MEM_FIELD &&
             opcode[5:3] != 3'd3 && opcode[5:3] != 3'd7)
      flowIdx = flowAlu;   // SBC and CP left out
  end

endmodule

/* gbCpuPkg.sv */
`include "gbCpu_params.svh"

package gbCpuPkg;

  // ------------------------------------------------------------
  // Micro-op encoding
  // ------------------------------------------------------------
  typedef enum logic [4:0] {
    cmdNop,
    cmdFetch,     // read at PC, PC++
    cmdReadImm,   // read at PC into temp, PC++
    cmdLoadImm,
    cmdMove,
    cmdAluOp,
    cmdIncDec,
    cmdStoreHl,
    cmdJumpRel,
    cmdDispatch
  } uopCmdE;

  typedef enum logic [1:0] {
    eofContinue,
    eofEnd,
    eofEndIfZ,
    eofEndIfNz
  } eofSelE;

  typedef struct packed {
    uopCmdE cmd;
    eofSelE eof;
    logic   srcHigh;  // Operand from opcode bits 5:3 instead of 2:0
  } uopT;

  // Z80 register field encoding
  typedef enum logic [2:0] {
    regB, regC, regD, regE, regH, regL, regHlMem, regA
  } regIdxT;

  typedef enum logic [2:0] {
    aluAdd, aluAdc, aluSub, aluAnd, aluXor, aluOr, aluInc, aluDec
  } aluOpE;

  typedef struct packed {
    logic       z;
    logic       n;
    logic       h;
    logic       c;
    logic [3:0] zero;
  } flagsT;

  typedef struct packed {
    logic [`GB_ADDR_W-1:0] addr;
    logic [`GB_DATA_W-1:0] wdata;
    logic                  we;
  } busReqT;

  typedef struct packed {
    logic                  en;
    regIdxT                idx;
    logic [`GB_DATA_W-1:0] data;
  } regWriteT;

endpackage

/* gbCpu_params.svh */
`ifndef GBCPU_PARAMS_SVH
`define GBCPU_PARAMS_SVH

// ------------------------------------------------------------
// Datapath widths
// ------------------------------------------------------------
`define GB_DATA_W 8
`define GB_ADDR_W 16
`define GB_UPC_W 6

// ------------------------------------------------------------
// Reset values
// ------------------------------------------------------------
`define GB_RESET_PC 16'h0000
`define GB_FLAGS_RESET 8'hB0  // Z=1 N=0 H=1 C=1

// Micro-ROM entry shared by every instruction
`define GB_FLOW_FETCH 6'd0

// Opcodes decoded outside the regular field groups
`define GB_OP_JR_NZ 8'h20

// Opcode field for (HL) in the register slots
`define GB_HL_MEM_FIELD 3'd6

`endif
